// File: csr_arch_pkg.sv
/* RISC-V machine-mode architectural definitions: word and address types,
   privilege levels, mcause codes, CSR addresses and mstatus bit positions */
`default_nettype none

package csr_arch_pkg;

  // word width for CSR values and program counters
  typedef logic [31:0] xlen_t;

  typedef logic [11:0] csr_addr_t;   // csr number from the instruction

  // only M and U are implemented, S mode is absent
  typedef enum logic [1:0] {
    PRIV_U = 2'b00,
    PRIV_M = 2'b11
  } priv_t;

  // mcause value, interrupt bit always clear here
  typedef logic [31:0] cause_t;

  localparam cause_t CAUSE_ILLEGAL = 32'd2;   // illegal instruction
  localparam cause_t CAUSE_ECALL_U = 32'd8;   // environment call from U
  localparam cause_t CAUSE_ECALL_M = 32'd11;  // environment call from M

  // machine trap setup / handling addresses
  localparam csr_addr_t CSR_MSTATUS = 12'h300;
  localparam csr_addr_t CSR_MTVEC   = 12'h305;
  localparam csr_addr_t CSR_MEPC    = 12'h341;
  localparam csr_addr_t CSR_MCAUSE  = 12'h342;

  // mstatus fields that exist in this core
  localparam int MSTATUS_MIE    = 3;   // global interrupt enable
  localparam int MSTATUS_MPIE   = 7;   // MIE before the trap
  localparam int MSTATUS_MPP_LO = 11;  // previous privilege, low bit
  localparam int MSTATUS_MPP_HI = 12;  // previous privilege, high bit

endpackage

`default_nettype wire

// File: csr_xfer_pkg.sv
/* command and response formats between core and CSR unit, plus the
   operation encoding */
`default_nettype none

package csr_xfer_pkg;

  // system instruction kinds handled by the unit
  typedef enum logic [2:0] {
    OP_RW    = 3'd0,  // csrrw
    OP_RS    = 3'd1,  // csrrs
    OP_RC    = 3'd2,  // csrrc
    OP_ECALL = 3'd3,
    OP_MRET  = 3'd4
  } csr_op_t;

  // one retired system instruction
  typedef struct packed {
    csr_op_t                 op;
    csr_arch_pkg::csr_addr_t addr;     // ignored for ecall and mret
    csr_arch_pkg::xlen_t     operand;  // rs1 value or zero-extended uimm
    csr_arch_pkg::xlen_t     pc;       // pc of the instruction itself
  } csr_cmd_t;

  // answer sent back to the core for every command
  typedef struct packed {
    csr_arch_pkg::xlen_t rdata;     // old csr value, zero on trap
    logic                redirect;  // fetch must restart at target
    csr_arch_pkg::xlen_t target;
    logic                trap;      // instruction trapped
    csr_arch_pkg::priv_t priv;      // privilege after this command
  } csr_rsp_t;

endpackage

`default_nettype wire

// File: csr_cmd_rx.sv
/* four-phase command receiver, latches one command and offers it downstream
   over valid/ready */
`timescale 1ns/1ns
`default_nettype none

module csr_cmd_rx (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   cmd_req,
  input  csr_xfer_pkg::csr_cmd_t cmd,
  output logic                   cmd_ack,
  output csr_xfer_pkg::csr_cmd_t cmd_out,
  output logic                   cmd_valid,
  input  logic                   cmd_ready
);

  typedef enum logic [1:0] {
    RX_IDLE,      // ack low, may accept a request
    RX_ACKED,     // first cycle of ack high
    RX_WAIT_LOW   // ack still high, waiting for req to fall
  } rx_state_t;

  rx_state_t state;
  logic      full;    // holder owns a command not yet taken
  logic      accept;  // latch the incoming command this edge

  // never ack while the previous command still sits in the holder
  assign accept = (state == RX_IDLE) && cmd_req && !full;

  assign cmd_ack   = (state != RX_IDLE);  // registered through the state
  assign cmd_valid = full;

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= RX_IDLE;
    end else begin
      case (state)
        RX_IDLE: if (accept) state <= RX_ACKED;
        RX_ACKED: state <= cmd_req ? RX_WAIT_LOW : RX_IDLE;
        RX_WAIT_LOW: if (!cmd_req) state <= RX_IDLE;  // ack falls next cycle
        default: state <= RX_IDLE;
      endcase
    end
  end

  // full flag, set on accept, cleared when downstream takes it
  always_ff @(posedge clk) begin
    if (reset) begin
      full <= 1'b0;
    end else if (accept) begin
      full <= 1'b1;
    end else if (cmd_valid && cmd_ready) begin
      full <= 1'b0;
    end
  end

  // payload only, qualified by full
  always_ff @(posedge clk) begin
    if (accept) cmd_out <= cmd;
  end

endmodule

`default_nettype wire

// File: csr_exec.sv
/* machine-mode CSR file and privilege state: csr read/modify/write,
   legality check, ecall and illegal-access traps, mret */
`timescale 1ns/1ns
`default_nettype none

module csr_exec #(
  parameter csr_arch_pkg::xlen_t MTVEC_RESET = 32'h0000_0100
) (
  input  logic                   clk,
  input  logic                   reset,
  input  csr_xfer_pkg::csr_cmd_t cmd,
  input  logic                   cmd_valid,
  output logic                   cmd_ready,
  output csr_xfer_pkg::csr_rsp_t res,
  output logic                   res_valid,
  input  logic                   res_ready
);

  import csr_arch_pkg::*;
  import csr_xfer_pkg::*;

  // architectural state
  xlen_t  mstatus;
  xlen_t  mtvec;
  xlen_t  mepc;
  cause_t mcause;
  priv_t  priv;

  // state after the current command, committed on fire
  xlen_t  mstatus_nxt;
  xlen_t  mtvec_nxt;
  xlen_t  mepc_nxt;
  cause_t mcause_nxt;
  priv_t  priv_nxt;

  logic  fire;       // command consumed and result handed on
  logic  is_csr_op;  // csrrw / csrrs / csrrc
  logic  is_ecall;
  logic  is_mret;
  logic  illegal;
  logic  trap;
  xlen_t old_val;    // csr value before the write
  xlen_t wr_val;     // value the csr op wants to write

  // mstatus keeps MIE, MPIE and MPP; MPP of 01 or 10 is not a mode here
  function automatic xlen_t legal_mstatus(xlen_t v);
    xlen_t r;
    r = '0;
    r[MSTATUS_MIE]  = v[MSTATUS_MIE];
    r[MSTATUS_MPIE] = v[MSTATUS_MPIE];
    if (v[MSTATUS_MPP_HI:MSTATUS_MPP_LO] == PRIV_M) begin
      r[MSTATUS_MPP_HI:MSTATUS_MPP_LO] = PRIV_M;
    end
    return r;
  endfunction

  // single stage, the sender's space decides for both sides
  assign cmd_ready = res_ready;
  assign res_valid = cmd_valid;
  assign fire      = cmd_valid && res_ready;

  // decode and legality
  always_comb begin
    is_csr_op = (cmd.op == OP_RW) || (cmd.op == OP_RS) || (cmd.op == OP_RC);
    is_ecall  = (cmd.op == OP_ECALL);
    is_mret   = (cmd.op == OP_MRET);
    if (priv == PRIV_U) begin
      illegal = !is_ecall;  // U may only ecall
    end else begin
      illegal = !(is_csr_op || is_ecall || is_mret);  // reserved op codes
    end
    trap = illegal || is_ecall;
  end

  // csr read, unknown numbers read as zero
  always_comb begin
    case (cmd.addr)
      CSR_MSTATUS: old_val = mstatus;
      CSR_MTVEC:   old_val = mtvec;
      CSR_MEPC:    old_val = mepc;
      CSR_MCAUSE:  old_val = mcause;
      default:     old_val = '0;
    endcase
  end

  // read-modify-write value
  always_comb begin
    case (cmd.op)
      OP_RS:   wr_val = old_val | cmd.operand;   // set bits
      OP_RC:   wr_val = old_val & ~cmd.operand;  // clear bits
      default: wr_val = cmd.operand;
    endcase
  end

  always_comb begin
    mstatus_nxt = mstatus;
    mtvec_nxt   = mtvec;
    mepc_nxt    = mepc;
    mcause_nxt  = mcause;
    priv_nxt    = priv;
    if (trap) begin
      mepc_nxt = {cmd.pc[31:2], 2'b00};  // IALIGN is 32
      if (illegal) begin
        mcause_nxt = CAUSE_ILLEGAL;
      end else if (priv == PRIV_U) begin
        mcause_nxt = CAUSE_ECALL_U;
      end else begin
        mcause_nxt = CAUSE_ECALL_M;
      end
      // push the interrupt-enable / privilege stack
      mstatus_nxt[MSTATUS_MPP_HI:MSTATUS_MPP_LO] = priv;
      mstatus_nxt[MSTATUS_MPIE] = mstatus[MSTATUS_MIE];
      mstatus_nxt[MSTATUS_MIE]  = 1'b0;
      priv_nxt = PRIV_M;
    end else if (is_mret) begin
      // pop the stack; MPP is always 00 or 11 so the cast is safe
      priv_nxt = priv_t'(mstatus[MSTATUS_MPP_HI:MSTATUS_MPP_LO]);
      mstatus_nxt[MSTATUS_MIE]  = mstatus[MSTATUS_MPIE];
      mstatus_nxt[MSTATUS_MPIE] = 1'b1;
      mstatus_nxt[MSTATUS_MPP_HI:MSTATUS_MPP_LO] = PRIV_U;
    end else begin
      case (cmd.addr)
        CSR_MSTATUS: mstatus_nxt = legal_mstatus(wr_val);
        CSR_MTVEC:   mtvec_nxt   = {wr_val[31:2], 2'b00};  // direct mode only
        CSR_MEPC:    mepc_nxt    = {wr_val[31:2], 2'b00};
        CSR_MCAUSE:  mcause_nxt  = wr_val;
        default:     ;  // unknown csr, write dropped
      endcase
    end
  end

  // response, purely from the current command and state
  always_comb begin
    res      = '0;
    res.priv = priv_nxt;
    if (trap) begin
      res.redirect = 1'b1;
      res.trap     = 1'b1;
      res.target   = mtvec;
    end else if (is_mret) begin
      res.redirect = 1'b1;
      res.target   = mepc;
    end else begin
      res.rdata = old_val;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      mstatus <= '0;
      mtvec   <= MTVEC_RESET;
      mepc    <= '0;
      mcause  <= '0;
      priv    <= PRIV_M;
    end else if (fire) begin
      mstatus <= mstatus_nxt;
      mtvec   <= mtvec_nxt;
      mepc    <= mepc_nxt;
      mcause  <= mcause_nxt;
      priv    <= priv_nxt;
    end
  end

endmodule

`default_nettype wire

// File: csr_rsp_tx.sv
/* one-entry response holder driving the four-phase response link */
`timescale 1ns/1ns
`default_nettype none

module csr_rsp_tx (
  input  logic                   clk,
  input  logic                   reset,
  input  csr_xfer_pkg::csr_rsp_t res,
  input  logic                   res_valid,
  output logic                   res_ready,
  output logic                   rsp_req,
  output csr_xfer_pkg::csr_rsp_t rsp,
  input  logic                   rsp_ack
);

  typedef enum logic [1:0] {
    TX_EMPTY,     // holder free
    TX_REQ,       // req high, waiting for ack
    TX_WAIT_LOW   // req dropped, waiting for ack to fall
  } tx_state_t;

  tx_state_t state;
  logic      load;  // take a result into the holder

  assign res_ready = (state == TX_EMPTY);
  assign load      = res_valid && res_ready;
  assign rsp_req   = (state == TX_REQ);  // rises the cycle after load

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= TX_EMPTY;
    end else begin
      case (state)
        TX_EMPTY: if (load) state <= TX_REQ;
        TX_REQ: if (rsp_ack) state <= TX_WAIT_LOW;
        // holder only frees once the handshake is fully closed
        TX_WAIT_LOW: if (!rsp_ack) state <= TX_EMPTY;
        default: state <= TX_EMPTY;
      endcase
    end
  end

  // held stable for the whole req-high phase
  always_ff @(posedge clk) begin
    if (load) rsp <= res;
  end

endmodule

`default_nettype wire

// File: csr_unit.sv
/* CSR unit top: command receiver, executor and response sender */
`timescale 1ns/1ns
`default_nettype none

module csr_unit #(
  parameter csr_arch_pkg::xlen_t MTVEC_RESET = 32'h0000_0100
) (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   cmd_req,
  input  csr_xfer_pkg::csr_cmd_t cmd,
  output logic                   cmd_ack,
  output logic                   rsp_req,
  output csr_xfer_pkg::csr_rsp_t rsp,
  input  logic                   rsp_ack
);

  import csr_xfer_pkg::*;

  csr_cmd_t cmd_q;      // command from the holder
  logic     cmd_valid;
  logic     cmd_ready;
  csr_rsp_t res;        // result toward the sender
  logic     res_valid;
  logic     res_ready;

  csr_cmd_rx u_rx (
    .clk       (clk),
    .reset     (reset),
    .cmd_req   (cmd_req),
    .cmd       (cmd),
    .cmd_ack   (cmd_ack),
    .cmd_out   (cmd_q),
    .cmd_valid (cmd_valid),
    .cmd_ready (cmd_ready)
  );

  csr_exec #(
    .MTVEC_RESET (MTVEC_RESET)
  ) u_exec (
    .clk       (clk),
    .reset     (reset),
    .cmd       (cmd_q),
    .cmd_valid (cmd_valid),
    .cmd_ready (cmd_ready),
    .res       (res),
    .res_valid (res_valid),
    .res_ready (res_ready)
  );

  csr_rsp_tx u_tx (
    .clk       (clk),
    .reset     (reset),
    .res       (res),
    .res_valid (res_valid),
    .res_ready (res_ready),
    .rsp_req   (rsp_req),
    .rsp       (rsp),
    .rsp_ack   (rsp_ack)
  );

endmodule

`default_nettype wire

// File: csr_unit_props.sv
/* concurrent checks on the command and response four-phase links,
   bound into the CSR unit top level */
`timescale 1ns/1ns
`default_nettype none

module csr_unit_props (
  input logic                   clk,
  input logic                   reset,
  input logic                   cmd_req,
  input logic                   cmd_ack,
  input logic                   rsp_req,
  input csr_xfer_pkg::csr_rsp_t rsp,
  input logic                   rsp_ack
);

  // core only drops its request once the unit acks
  cmd_req_held: assert property (@(posedge clk) disable iff (reset)
    $fell(cmd_req) |-> cmd_ack)
    else $error("cmd_req fell before cmd_ack rose");

  cmd_ack_held: assert property (@(posedge clk) disable iff (reset)
    cmd_ack && cmd_req |=> cmd_ack)  // ack only falls after req
    else $error("cmd_ack fell while cmd_req was high");

  rsp_req_held: assert property (@(posedge clk) disable iff (reset)
    rsp_req && !rsp_ack |=> rsp_req)
    else $error("rsp_req fell before rsp_ack rose");

  rsp_stable: assert property (@(posedge clk) disable iff (reset)
    rsp_req |=> !rsp_req || $stable(rsp))
    else $error("rsp changed while rsp_req was high");

  idle_after_reset: assert property (@(posedge clk)
    reset |=> !cmd_ack && !rsp_req)
    else $error("cmd_ack or rsp_req high right after reset");

endmodule

bind csr_unit csr_unit_props u_props (
  .clk     (clk),
  .reset   (reset),
  .cmd_req (cmd_req),
  .cmd_ack (cmd_ack),
  .rsp_req (rsp_req),
  .rsp     (rsp),
  .rsp_ack (rsp_ack)
);

`default_nettype wire

// File: csr_unit_tb.sv
/* testbench for the CSR unit: random commands over the four-phase link,
   reference model of the CSR rules, response compare tasks and run limit */
`timescale 1ns/1ns
`default_nettype none

module csr_unit_tb;

  import csr_arch_pkg::*;
  import csr_xfer_pkg::*;

  localparam int    NUM_CMDS   = 400;
  localparam int    MAX_CYCLES = NUM_CMDS * 40;  // far above the worst handshake
  localparam xlen_t MTVEC_INIT = 32'h0000_0100;

  logic     clk;
  logic     reset;
  logic     cmd_req;
  csr_cmd_t cmd;
  logic     cmd_ack;
  logic     rsp_req;
  csr_rsp_t rsp;
  logic     rsp_ack;

  integer   seed;
  int       cycles = 0;
  int       rsp_count = 0;
  csr_rsp_t expected_q[$];           // one entry per command sent, oldest first

  csr_cmd_t cmd_list [NUM_CMDS];
  int       gap_cycles [NUM_CMDS];   // idle cycles before each request
  int       ack_delay [NUM_CMDS];    // cycles before acking each response

  // reference state
  xlen_t  model_mstatus;             // only MIE, MPIE and a legal MPP ever set
  xlen_t  model_mtvec;
  xlen_t  model_mepc;
  cause_t model_mcause;
  priv_t  model_priv;
  int     illegal_traps;
  int     u_ecalls;
  int     mrets_to_u;

  csr_unit #(
    .MTVEC_RESET (MTVEC_INIT)
  ) dut0 (
    .clk     (clk),
    .reset   (reset),
    .cmd_req (cmd_req),
    .cmd     (cmd),
    .cmd_ack (cmd_ack),
    .rsp_req (rsp_req),
    .rsp     (rsp),
    .rsp_ack (rsp_ack)
  );

  initial clk = 1'b0;
  always #20 clk = ~clk;  // 40 ns period

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      stop_on_failure($sformatf("timeout after %0d cycles, only %0d of %0d responses came back",
                                cycles, rsp_count, NUM_CMDS));
    end
  end

  task automatic stop_on_failure(input string what);
    $display("%s", what);
    $display("Finished with errors");
    $fatal(1, "run stopped at the first failed check");
  endtask

  task automatic check_data(input string what, input xlen_t got, input xlen_t exp);
    if (got !== exp) begin
      stop_on_failure($sformatf("ERROR at %0t ns: %s is %h, expected %h",
                                $time, what, got, exp));
    end
  endtask

  task automatic check_priv(input string what, input priv_t got, input priv_t exp);
    if (got !== exp) begin
      stop_on_failure($sformatf("ERROR at %0t ns: %s is %b, expected %b",
                                $time, what, got, exp));
    end
  endtask

  task automatic check_flag(input string what, input logic got, input logic exp);
    if (got !== exp) begin
      stop_on_failure($sformatf("ERROR at %0t ns: %s is %b, expected %b",
                                $time, what, got, exp));
    end
  endtask

  task automatic model_reset();
    model_mstatus = '0;
    model_mtvec   = MTVEC_INIT;
    model_mepc    = '0;
    model_mcause  = '0;
    model_priv    = PRIV_M;
    illegal_traps = 0;
    u_ecalls      = 0;
    mrets_to_u    = 0;
  endtask

  // applies one command to the reference state, returns the expected answer
  task automatic model_execute(input csr_cmd_t c, output csr_rsp_t exp);
    xlen_t old_val;
    xlen_t new_val;
    logic  mie;
    logic  mpie;
    mie  = model_mstatus[3];
    mpie = model_mstatus[7];
    case (c.addr)
      CSR_MSTATUS: old_val = model_mstatus;
      CSR_MTVEC:   old_val = model_mtvec;
      CSR_MEPC:    old_val = model_mepc;
      CSR_MCAUSE:  old_val = model_mcause;
      default:     old_val = '0;  // unknown csr
    endcase
    exp = '0;
    if (c.op == OP_ECALL || model_priv == PRIV_U) begin
      // in U every command other than ecall is an illegal access
      exp.redirect = 1'b1;
      exp.trap     = 1'b1;
      exp.target   = model_mtvec;
      if (c.op != OP_ECALL) begin
        model_mcause = CAUSE_ILLEGAL;
        illegal_traps++;
      end else if (model_priv == PRIV_U) begin
        model_mcause = CAUSE_ECALL_U;
        u_ecalls++;
      end else begin
        model_mcause = CAUSE_ECALL_M;
      end
      model_mepc    = c.pc & 32'hffff_fffc;
      model_mstatus = {19'b0, model_priv, 3'b0, mie, 7'b0};  // MPP, MPIE, MIE=0
      model_priv    = PRIV_M;
    end else if (c.op == OP_MRET) begin
      exp.redirect = 1'b1;
      exp.target   = model_mepc;
      if (model_mstatus[12:11] == 2'b11) begin
        model_priv = PRIV_M;
      end else begin
        model_priv = PRIV_U;
        mrets_to_u++;
      end
      model_mstatus = {19'b0, 2'b00, 3'b0, 1'b1, 3'b0, mpie, 3'b0};
    end else begin
      exp.rdata = old_val;
      case (c.op)
        OP_RS:   new_val = old_val | c.operand;
        OP_RC:   new_val = old_val & ~c.operand;
        default: new_val = c.operand;
      endcase
      case (c.addr)
        CSR_MSTATUS: model_mstatus = (new_val & 32'h0000_0088) |
                                     ((new_val[12:11] == 2'b11) ? 32'h0000_1800 : 32'h0);
        CSR_MTVEC:   model_mtvec  = new_val & 32'hffff_fffc;
        CSR_MEPC:    model_mepc   = new_val & 32'hffff_fffc;
        CSR_MCAUSE:  model_mcause = new_val;
        default:     ;
      endcase
    end
    exp.priv = model_priv;
  endtask

  task automatic draw_command(output csr_cmd_t c);
    int pick;
    pick = $unsigned($random(seed)) % 100;
    if (pick < 25) begin
      c.op = OP_RW;
    end else if (pick < 45) begin
      c.op = OP_RS;
    end else if (pick < 65) begin
      c.op = OP_RC;
    end else if (pick < 80) begin
      c.op = OP_ECALL;
    end else begin
      c.op = OP_MRET;  // from M with MPP=00 this drops to U
    end
    pick = $unsigned($random(seed)) % 10;
    case (pick)
      0, 1:    c.addr = CSR_MSTATUS;
      2, 3:    c.addr = CSR_MTVEC;
      4, 5:    c.addr = CSR_MEPC;
      6, 7:    c.addr = CSR_MCAUSE;
      default: c.addr = 12'($random(seed));  // almost always unknown
    endcase
    c.operand = $random(seed);  // full width, hits MPP and the low bits
    c.pc      = $random(seed);
  endtask

  task automatic drive_commands();
    csr_rsp_t exp;
    for (int i = 0; i < NUM_CMDS; i++) begin
      repeat (gap_cycles[i]) @(negedge clk);
      while (cmd_ack) @(negedge clk);  // last handshake not closed yet
      model_execute(cmd_list[i], exp);
      expected_q.push_back(exp);
      cmd     = cmd_list[i];
      cmd_req = 1'b1;
      @(negedge clk);
      while (!cmd_ack) @(negedge clk);  // held off while the holder is full
      cmd_req = 1'b0;
      @(negedge clk);
    end
  endtask

  task automatic collect_responses();
    csr_rsp_t exp;
    for (int n = 0; n < NUM_CMDS; n++) begin
      while (!rsp_req) @(negedge clk);
      repeat (ack_delay[n]) @(negedge clk);  // rsp has to stay put meanwhile
      if (expected_q.size() == 0) begin
        stop_on_failure("a response arrived while no command was outstanding");
      end else begin
        exp = expected_q.pop_front();
        check_data($sformatf("response %0d rdata", n), rsp.rdata, exp.rdata);
        check_data($sformatf("response %0d target", n), rsp.target, exp.target);
        check_flag($sformatf("response %0d redirect", n), rsp.redirect, exp.redirect);
        check_flag($sformatf("response %0d trap", n), rsp.trap, exp.trap);
        check_priv($sformatf("response %0d priv", n), rsp.priv, exp.priv);
        rsp_ack = 1'b1;
        @(negedge clk);
        while (rsp_req) @(negedge clk);
        rsp_ack = 1'b0;
        rsp_count++;
      end
    end
  endtask

  initial begin
    reset   = 1'b1;
    cmd_req = 1'b0;
    cmd     = '0;
    rsp_ack = 1'b0;
    seed    = 32'hd5e179f1;
    for (int i = 0; i < NUM_CMDS; i++) begin
      draw_command(cmd_list[i]);
      gap_cycles[i] = $unsigned($random(seed)) % 3;
      ack_delay[i]  = $unsigned($random(seed)) % 8;  // back-pressure on the sender
    end
    model_reset();
    repeat (3) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    fork
      drive_commands();
      collect_responses();
    join
    repeat (8) @(negedge clk);  // room for a stray extra response
    if (rsp_req || expected_q.size() != 0) begin
      stop_on_failure("response count does not match the number of commands sent");
    end else if (illegal_traps == 0 || u_ecalls == 0 || mrets_to_u == 0) begin
      stop_on_failure("the random commands never reached user mode traps");
    end else begin
      $display("%0d commands: %0d illegal traps, %0d ecalls from U, %0d mret into U",
               NUM_CMDS, illegal_traps, u_ecalls, mrets_to_u);
      $display("Finished with no errors");
      $finish;
    end
  end

endmodule

`default_nettype wire

// File: filelist.f
csr_arch_pkg.sv
csr_xfer_pkg.sv
csr_cmd_rx.sv
csr_exec.sv
csr_rsp_tx.sv
csr_unit.sv
csr_unit_props.sv
csr_unit_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the CSR unit testbench with Verilator, output kept in sim.log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert --timescale 1ns/1ns \
  -f filelist.f --top-module csr_unit_tb \
  || { echo "verilator build failed"; exit 1; }
# a non-zero exit of the simulation counts as a failed run
./obj_dir/Vcsr_unit_tb > sim.log 2>&1 \
  || echo "Finished with errors" >> sim.log
cat sim.log
grep -q "Finished with errors" sim.log \
  && { echo "SIMULATION FAILED"; exit 1; } \
  || { echo "SIMULATION PASSED"; exit 0; }
